//--- colorbar_pkg.sv
/*
 * colour bar generator, shared definitions
 * 640x480 at 60 Hz display timing for a 25 MHz dot clock,
 * bar geometry, colour constants and the common vector types
 */

package colorbar_pkg;

	// ----------------------------------------------------------
	// vector types

	typedef logic [11:0] count_t;		// dot or line counter value
	typedef logic [23:0] pixel_t;		// packed red, green, blue
	typedef logic [7:0] channel_t;		// one colour component
	typedef logic [2:0] bar_index_t;	// bar column or row band, 0..7

	// ----------------------------------------------------------
	// horizontal timing
	// dots are numbered from 1, the counter ends a line at H_TOTAL

	localparam count_t H_SYNC_END = 12'd96;	// hsync low for dots 1..96
	localparam count_t H_ACTIVE_START = 12'd144;	// back porch ends here
	localparam count_t H_ACTIVE_END = 12'd784;	// 640 dots of picture
	localparam count_t H_TOTAL = 12'd800;		// last dot of a line

	// ----------------------------------------------------------
	// vertical timing
	// lines are numbered from 0, the counter wraps after V_TOTAL

	localparam count_t V_SYNC_END = 12'd1;		// vsync low on lines 0 and 1
	localparam count_t V_ACTIVE_START = 12'd34;	// first picture line follows
	localparam count_t V_ACTIVE_END = 12'd514;	// 480 picture lines
	localparam count_t V_TOTAL = 12'd524;		// 525 lines per frame

	// ----------------------------------------------------------
	// bar geometry

	localparam count_t BAR_WIDTH = 12'd80;		// 8 columns over 640 dots
	localparam count_t BAR_HEIGHT = 12'd60;	// 8 bands over 480 lines

	// ----------------------------------------------------------
	// colours

	localparam pixel_t COLOR_BLACK = 24'h000000;
	localparam pixel_t COLOR_WHITE = 24'hffffff;

endpackage

//--- vga_timing_gen.sv
/*
 * VGA timing generator
 * dot and line counters with registered compare strobes that set
 * and clear the sync and blank levels, all levels active low
 */

`timescale 1ns/1ps

module vga_timing_gen (
	input	logic	D_CLK,
	input	logic	D_RST_N,
	output	logic	hsync_n,
	output	logic	vsync_n,
	output	logic	blank_n,
	output	logic	vblank_n
);

	import colorbar_pkg::*;

	count_t	hcount_r;
	count_t	vcount_r;

	logic	h_sync_end_r;		// hcount at H_SYNC_END
	logic	h_act_start_r;
	logic	h_act_end_r;
	logic	h_line_end_r;		// last dot of the line
	logic	v_sync_end_r;
	logic	v_act_start_r;
	logic	v_act_end_r;
	logic	v_frame_end_r;

	logic	hsync_n_r;
	logic	vsync_n_r;
	logic	hblank_n_r;
	logic	vblank_n_r;
	logic	blank_n_r;

	logic	hsync_n_nxt;
	logic	vsync_n_nxt;
	logic	hblank_n_nxt;
	logic	vblank_n_nxt;

	// ----------------------------------------------------------
	// counters and strobes

	// h strobes compare one dot early so they line up with the count
	always_ff @(posedge D_CLK or negedge D_RST_N)
	begin
		if (!D_RST_N)
		begin
			hcount_r <= count_t'(1);
			vcount_r <= '0;
			h_sync_end_r <= 1'b0;
			h_act_start_r <= 1'b0;
			h_act_end_r <= 1'b0;
			h_line_end_r <= 1'b0;
			v_sync_end_r <= 1'b0;
			v_act_start_r <= 1'b0;
			v_act_end_r <= 1'b0;
			v_frame_end_r <= 1'b0;
		end
		else
		begin
			if (h_line_end_r)
			begin
				hcount_r <= count_t'(1);
				vcount_r <= v_frame_end_r ? '0 : vcount_r + count_t'(1);
			end
			else
				hcount_r <= hcount_r + count_t'(1);

			h_sync_end_r <= (hcount_r == H_SYNC_END - count_t'(1));
			h_act_start_r <= (hcount_r == H_ACTIVE_START - count_t'(1));
			h_act_end_r <= (hcount_r == H_ACTIVE_END - count_t'(1));
			h_line_end_r <= (hcount_r == H_TOTAL - count_t'(1));

			v_sync_end_r <= (vcount_r == V_SYNC_END);	// only sampled at line end
			v_act_start_r <= (vcount_r == V_ACTIVE_START);
			v_act_end_r <= (vcount_r == V_ACTIVE_END);
			v_frame_end_r <= (vcount_r == V_TOTAL);
		end
	end

	// ----------------------------------------------------------
	// sync and blank levels

	always_comb
	begin
		hsync_n_nxt = hsync_n_r;
		hblank_n_nxt = hblank_n_r;
		vsync_n_nxt = vsync_n_r;
		vblank_n_nxt = vblank_n_r;

		if (h_line_end_r)
			hsync_n_nxt = 1'b0;
		else if (h_sync_end_r)
			hsync_n_nxt = 1'b1;

		if (h_act_end_r)
			hblank_n_nxt = 1'b0;
		else if (h_act_start_r)
			hblank_n_nxt = 1'b1;

		// vertical levels move together with the hsync fall
		if (h_line_end_r)
		begin
			if (v_frame_end_r)
				vsync_n_nxt = 1'b0;
			else if (v_sync_end_r)
				vsync_n_nxt = 1'b1;

			if (v_act_end_r)
				vblank_n_nxt = 1'b0;
			else if (v_act_start_r)
				vblank_n_nxt = 1'b1;
		end
	end

	always_ff @(posedge D_CLK or negedge D_RST_N)
	begin
		if (!D_RST_N)
		begin
			hsync_n_r <= 1'b0;
			vsync_n_r <= 1'b0;
			hblank_n_r <= 1'b0;
			vblank_n_r <= 1'b0;
			blank_n_r <= 1'b0;
		end
		else
		begin
			hsync_n_r <= hsync_n_nxt;
			vsync_n_r <= vsync_n_nxt;
			hblank_n_r <= hblank_n_nxt;
			vblank_n_r <= vblank_n_nxt;
			blank_n_r <= hblank_n_nxt & vblank_n_nxt;	// active only inside both
		end
	end

	assign hsync_n = hsync_n_r;
	assign vsync_n = vsync_n_r;
	assign blank_n = blank_n_r;
	assign vblank_n = vblank_n_r;

endmodule

//--- bar_locator.sv
/*
 * bar locator
 * tags each pixel with its bar column and row band and delays
 * the sync and blank levels by the same single clock
 */

`timescale 1ns/1ps

module bar_locator (
	input	logic			D_CLK,
	input	logic			D_RST_N,
	input	logic			hsync_n_in,
	input	logic			vsync_n_in,
	input	logic			blank_n_in,
	input	logic			vblank_n_in,
	output	colorbar_pkg::bar_index_t	column,
	output	colorbar_pkg::bar_index_t	band,
	output	logic			hsync_n,
	output	logic			vsync_n,
	output	logic			blank_n
);

	import colorbar_pkg::*;

	count_t		pix_cnt_r;	// pixels of the current bar seen so far
	count_t		line_cnt_r;	// finished lines of the current band
	bar_index_t	column_r;
	bar_index_t	band_r;
	logic		hsync_n_r;
	logic		vsync_n_r;
	logic		blank_n_r;
	logic		line_done;

	assign line_done = blank_n_r & ~blank_n_in;	// end of an active line

	// ----------------------------------------------------------
	// level delay

	always_ff @(posedge D_CLK or negedge D_RST_N)
	begin
		if (!D_RST_N)
		begin
			hsync_n_r <= 1'b0;
			vsync_n_r <= 1'b0;
			blank_n_r <= 1'b0;
		end
		else
		begin
			hsync_n_r <= hsync_n_in;
			vsync_n_r <= vsync_n_in;
			blank_n_r <= blank_n_in;
		end
	end

	// ----------------------------------------------------------
	// column and band

	always_ff @(posedge D_CLK or negedge D_RST_N)
	begin
		if (!D_RST_N)
		begin
			pix_cnt_r <= '0;
			column_r <= '0;
		end
		else if (!blank_n_in)
		begin
			pix_cnt_r <= '0;
			column_r <= '0;
		end
		else if (pix_cnt_r == BAR_WIDTH)
		begin
			pix_cnt_r <= count_t'(1);	// first pixel of next bar
			column_r <= column_r + bar_index_t'(1);
		end
		else
			pix_cnt_r <= pix_cnt_r + count_t'(1);
	end

	always_ff @(posedge D_CLK or negedge D_RST_N)
	begin
		if (!D_RST_N)
		begin
			line_cnt_r <= '0;
			band_r <= '0;
		end
		else
		begin
			if (!vsync_n_in)
				line_cnt_r <= '0;
			else if (line_done)
				line_cnt_r <= (line_cnt_r == BAR_HEIGHT - count_t'(1)) ?
					'0 : line_cnt_r + count_t'(1);

			if (!vblank_n_in)
				band_r <= '0;
			else if (line_done && line_cnt_r == BAR_HEIGHT - count_t'(1))
				band_r <= band_r + bar_index_t'(1);
		end
	end

	assign column = column_r;
	assign band = band_r;
	assign hsync_n = hsync_n_r;
	assign vsync_n = vsync_n_r;
	assign blank_n = blank_n_r;

endmodule

//--- bar_palette.sv
/*
 * bar palette
 * looks up the colour of a bar column within its row band and
 * registers it alongside the delayed sync and blank levels
 */

`timescale 1ns/1ps

module bar_palette (
	input	logic			D_CLK,
	input	logic			D_RST_N,
	input	colorbar_pkg::bar_index_t	column,
	input	colorbar_pkg::bar_index_t	band,
	input	logic			hsync_n_in,
	input	logic			vsync_n_in,
	input	logic			blank_n_in,
	output	colorbar_pkg::pixel_t	color,
	output	logic			hsync_n,
	output	logic			vsync_n,
	output	logic			blank_n
);

	import colorbar_pkg::*;

	pixel_t	color_nxt;
	pixel_t	color_r;
	logic	hsync_n_r;
	logic	vsync_n_r;
	logic	blank_n_r;

	// ----------------------------------------------------------
	// row tables

	always_comb
	begin
		color_nxt = COLOR_BLACK;
		case (band)
			3'd0, 3'd1, 3'd2, 3'd3:		// main bars
				case (column)
					3'd0: color_nxt = 24'h676767;	// 40% grey
					3'd1: color_nxt = 24'hbfbfbf;
					3'd2: color_nxt = 24'hbfbf00;	// yellow
					3'd3: color_nxt = 24'h00bfbf;	// cyan
					3'd4: color_nxt = 24'h00bf00;
					3'd5: color_nxt = 24'hbf00bf;	// magenta
					3'd6: color_nxt = 24'hbf0000;
					default: color_nxt = 24'h0000bf;
				endcase
			3'd4:				// cyan and white row
				case (column)
					3'd0: color_nxt = 24'h00ffff;
					3'd1: color_nxt = COLOR_WHITE;
					default: color_nxt = 24'hbfbfbf;	// 75% grey fill
				endcase
			3'd5:				// grey ramp
				case (column)
					3'd0: color_nxt = 24'hffff00;
					3'd1: color_nxt = COLOR_WHITE;
					3'd2: color_nxt = COLOR_BLACK;
					3'd3: color_nxt = 24'h333333;	// 20%
					3'd4: color_nxt = 24'h666666;
					3'd5: color_nxt = 24'h999999;	// 60%
					3'd6: color_nxt = 24'hcccccc;
					default: color_nxt = COLOR_WHITE;
				endcase
			default:			// black and white row, bands 6 and 7
				case (column)
					3'd0: color_nxt = 24'h262626;	// 15% grey
					3'd3, 3'd4: color_nxt = COLOR_WHITE;
					default: color_nxt = COLOR_BLACK;
				endcase
		endcase
	end

	// ----------------------------------------------------------
	// registers

	always_ff @(posedge D_CLK)
	begin
		color_r <= color_nxt;
	end

	always_ff @(posedge D_CLK or negedge D_RST_N)
	begin
		if (!D_RST_N)
		begin
			hsync_n_r <= 1'b0;
			vsync_n_r <= 1'b0;
			blank_n_r <= 1'b0;
		end
		else
		begin
			hsync_n_r <= hsync_n_in;
			vsync_n_r <= vsync_n_in;
			blank_n_r <= blank_n_in;
		end
	end

	assign color = color_r;
	assign hsync_n = hsync_n_r;
	assign vsync_n = vsync_n_r;
	assign blank_n = blank_n_r;

endmodule

//--- pixel_output.sv
/*
 * pixel output stage
 * applies white mode and blanking, splits the colour into
 * channels and registers every display output
 */

`timescale 1ns/1ps

module pixel_output (
	input	logic			D_CLK,
	input	logic			D_RST_N,
	input	logic			flat_white,
	input	colorbar_pkg::pixel_t	color,
	input	logic			hsync_n_in,
	input	logic			vsync_n_in,
	input	logic			blank_n_in,
	output	colorbar_pkg::channel_t	red,
	output	colorbar_pkg::channel_t	grn,
	output	colorbar_pkg::channel_t	blu,
	output	logic			hsync_n,
	output	logic			vsync_n,
	output	logic			blank_n
);

	import colorbar_pkg::*;

	logic	white_r;		// registered mode input
	pixel_t	pixel_r;
	logic	hsync_n_r;
	logic	vsync_n_r;
	logic	blank_n_r;

	always_ff @(posedge D_CLK or negedge D_RST_N)
	begin
		if (!D_RST_N)
		begin
			white_r <= 1'b0;
			pixel_r <= COLOR_BLACK;
			hsync_n_r <= 1'b0;
			vsync_n_r <= 1'b0;
			blank_n_r <= 1'b0;
		end
		else
		begin
			white_r <= flat_white;
			hsync_n_r <= hsync_n_in;
			vsync_n_r <= vsync_n_in;
			blank_n_r <= blank_n_in;

			if (!blank_n_in)
				pixel_r <= COLOR_BLACK;	// nothing outside the picture
			else if (white_r)
				pixel_r <= COLOR_WHITE;
			else
				pixel_r <= color;
		end
	end

	assign red = pixel_r[23:16];
	assign grn = pixel_r[15:8];
	assign blu = pixel_r[7:0];
	assign hsync_n = hsync_n_r;
	assign vsync_n = vsync_n_r;
	assign blank_n = blank_n_r;

endmodule

//--- colorbar_vga.sv
/*
 * colour bar test pattern generator, 640x480 at 60 Hz
 * timing, bar location, palette lookup and output stages in a chain
 */

`timescale 1ns/1ps

module colorbar_vga (
	input	logic			D_CLK,
	input	logic			D_RST_N,
	input	logic			flat_white,
	output	colorbar_pkg::channel_t	red,
	output	colorbar_pkg::channel_t	grn,
	output	colorbar_pkg::channel_t	blu,
	output	logic			hsync_n,
	output	logic			vsync_n,
	output	logic			blank_n
);

	import colorbar_pkg::*;

	// ----------------------------------------------------------
	// stage wires

	logic		tg_hsync_n;	// timing generator
	logic		tg_vsync_n;
	logic		tg_blank_n;
	logic		tg_vblank_n;

	bar_index_t	loc_column;	// bar locator
	bar_index_t	loc_band;
	logic		loc_hsync_n;
	logic		loc_vsync_n;
	logic		loc_blank_n;

	pixel_t		pal_color;	// palette
	logic		pal_hsync_n;
	logic		pal_vsync_n;
	logic		pal_blank_n;

	// ----------------------------------------------------------
	// stages

	vga_timing_gen u_timing (
		.D_CLK		(D_CLK),
		.D_RST_N	(D_RST_N),
		.hsync_n	(tg_hsync_n),
		.vsync_n	(tg_vsync_n),
		.blank_n	(tg_blank_n),
		.vblank_n	(tg_vblank_n)
	);

	bar_locator u_locator (
		.D_CLK		(D_CLK),
		.D_RST_N	(D_RST_N),
		.hsync_n_in	(tg_hsync_n),
		.vsync_n_in	(tg_vsync_n),
		.blank_n_in	(tg_blank_n),
		.vblank_n_in	(tg_vblank_n),
		.column		(loc_column),
		.band		(loc_band),
		.hsync_n	(loc_hsync_n),
		.vsync_n	(loc_vsync_n),
		.blank_n	(loc_blank_n)
	);

	bar_palette u_palette (
		.D_CLK		(D_CLK),
		.D_RST_N	(D_RST_N),
		.column		(loc_column),
		.band		(loc_band),
		.hsync_n_in	(loc_hsync_n),
		.vsync_n_in	(loc_vsync_n),
		.blank_n_in	(loc_blank_n),
		.color		(pal_color),
		.hsync_n	(pal_hsync_n),
		.vsync_n	(pal_vsync_n),
		.blank_n	(pal_blank_n)
	);

	pixel_output u_output (
		.D_CLK		(D_CLK),
		.D_RST_N	(D_RST_N),
		.flat_white	(flat_white),
		.color		(pal_color),
		.hsync_n_in	(pal_hsync_n),
		.vsync_n_in	(pal_vsync_n),
		.blank_n_in	(pal_blank_n),
		.red		(red),
		.grn		(grn),
		.blu		(blu),
		.hsync_n	(hsync_n),
		.vsync_n	(vsync_n),
		.blank_n	(blank_n)
	);

endmodule

//--- colorbar_properties.sv
/*
 * colour bar generator assertions
 * hsync pulse width, black during blanking and vsync moving
 * only together with the hsync fall
 */

`timescale 1ns/1ps

module colorbar_properties (
	input	logic			D_CLK,
	input	logic			D_RST_N,
	input	colorbar_pkg::channel_t	red,
	input	colorbar_pkg::channel_t	grn,
	input	colorbar_pkg::channel_t	blu,
	input	logic			hsync_n,
	input	logic			vsync_n,
	input	logic			blank_n
);

	import colorbar_pkg::*;

	logic	hsync_q;
	logic	vsync_q;
	logic	fall_seen;	// first pulse after reset is not a full one
	count_t	low_len;	// clocks hsync_n has been low

	always_ff @(posedge D_CLK or negedge D_RST_N)
	begin
		if (!D_RST_N)
		begin
			hsync_q <= 1'b0;
			vsync_q <= 1'b0;
			fall_seen <= 1'b0;
			low_len <= '0;
		end
		else
		begin
			hsync_q <= hsync_n;
			vsync_q <= vsync_n;
			if (hsync_q && !hsync_n)
				fall_seen <= 1'b1;
			if (!hsync_n)
				low_len <= low_len + count_t'(1);
			else
				low_len <= '0;
		end
	end

	hsync_width: assert property (@(posedge D_CLK) disable iff (!D_RST_N)
		(hsync_n && !hsync_q && fall_seen) |-> (low_len == count_t'(96)))
		else $error("hsync_n low pulse did not last 96 clocks");

	blank_black: assert property (@(posedge D_CLK) disable iff (!D_RST_N)
		!blank_n |-> ({red, grn, blu} == COLOR_BLACK))
		else $error("colour output not black while blank_n is low");

	vsync_on_hsync: assert property (@(posedge D_CLK) disable iff (!D_RST_N)
		(vsync_n != vsync_q) |-> (hsync_q && !hsync_n))
		else $error("vsync_n changed outside an hsync_n falling edge");

endmodule

bind colorbar_vga colorbar_properties u_props (
	.D_CLK		(D_CLK),
	.D_RST_N	(D_RST_N),
	.red		(red),
	.grn		(grn),
	.blu		(blu),
	.hsync_n	(hsync_n),
	.vsync_n	(vsync_n),
	.blank_n	(blank_n)
);

//--- tb_colorbar_vga.sv
/*
 * colour bar generator testbench
 * directed tests of reset levels, line and frame timing,
 * the bar pattern and white mode
 */

`timescale 1ns/1ps

module tb_colorbar_vga;

	import colorbar_pkg::*;

	localparam int FRAME_CLKS = 525 * 800;
	localparam int TEST_FRAMES = 6;		// partial first frame, timing, bars, white, bars
	localparam longint WATCHDOG_NS = longint'(16 + (TEST_FRAMES + 1) * FRAME_CLKS) * 100;

	// own copy of the row tables, columns 0..7
	localparam pixel_t ROW_A [8] = '{24'h676767, 24'hbfbfbf, 24'hbfbf00, 24'h00bfbf,
		24'h00bf00, 24'hbf00bf, 24'hbf0000, 24'h0000bf};
	localparam pixel_t ROW_B [8] = '{24'h00ffff, 24'hffffff, 24'hbfbfbf, 24'hbfbfbf,
		24'hbfbfbf, 24'hbfbfbf, 24'hbfbfbf, 24'hbfbfbf};
	localparam pixel_t ROW_C [8] = '{24'hffff00, 24'hffffff, 24'h000000, 24'h333333,
		24'h666666, 24'h999999, 24'hcccccc, 24'hffffff};
	localparam pixel_t ROW_D [8] = '{24'h262626, 24'h000000, 24'h000000, 24'hffffff,
		24'hffffff, 24'h000000, 24'h000000, 24'h000000};

	logic		D_CLK;
	logic		D_RST_N;
	logic		flat_white;
	channel_t	red;
	channel_t	grn;
	channel_t	blu;
	logic		hsync_n;
	logic		vsync_n;
	logic		blank_n;

	int		value_errs;
	int		other_errs;

	colorbar_vga UUT (
		.D_CLK		(D_CLK),
		.D_RST_N	(D_RST_N),
		.flat_white	(flat_white),
		.red		(red),
		.grn		(grn),
		.blu		(blu),
		.hsync_n	(hsync_n),
		.vsync_n	(vsync_n),
		.blank_n	(blank_n)
	);

	always #50 D_CLK = ~D_CLK;	// 100 ns period

	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests finished");
		$display("*** FAILED ***");
		$finish;
	end

	// ----------------------------------------------------------
	// compare tasks

	task automatic check_pixel(input string name, input pixel_t got, input pixel_t exp);
		if (got !== exp)
		begin
			$display("error: %s got %h expected %h", name, got, exp);
			value_errs++;
		end
	endtask

	task automatic check_count(input string name, input count_t got, input count_t exp);
		if (got !== exp)
		begin
			$display("error: %s got %h expected %h", name, got, exp);
			value_errs++;
		end
	endtask

	task automatic check_level(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("error: %s got %h expected %h", name, got, exp);
			value_errs++;
		end
	endtask

	function automatic pixel_t expected_color(input int col, input int band);
		if (band < 4)
			return ROW_A[col];
		else if (band == 4)
			return ROW_B[col];
		else if (band == 5)
			return ROW_C[col];
		return ROW_D[col];
	endfunction

	task automatic wait_vsync_fall(output logic found);
		logic prev;
		int n;
		prev = vsync_n;
		found = 1'b0;
		for (n = 0; n < FRAME_CLKS + 100 && !found; n++)
		begin
			@(negedge D_CLK);
			if (prev && !vsync_n)
				found = 1'b1;
			prev = vsync_n;
		end
		if (!found)
		begin
			$display("no falling edge of vsync_n within one frame");
			other_errs++;
		end
	endtask

	// ----------------------------------------------------------
	// directed tests

	task automatic test_reset_levels;
		repeat (16)
		begin
			@(negedge D_CLK);
			check_level("hsync_n", hsync_n, 1'b0);
			check_level("vsync_n", vsync_n, 1'b0);
			check_level("blank_n", blank_n, 1'b0);
			check_pixel("color", pixel_t'({red, grn, blu}), COLOR_BLACK);
		end
		D_RST_N = 1'b1;
	endtask

	task automatic test_line_timing;
		logic found;
		logic prev_h;
		int lines;
		int cycles;
		int high;
		int active;
		wait_vsync_fall(found);
		prev_h = hsync_n;
		lines = 0;
		cycles = 0;
		high = 0;
		active = 0;
		while (found && lines < 40)	// reaches the first active lines
		begin
			@(negedge D_CLK);
			cycles++;
			if (blank_n)
				high++;
			if (prev_h && !hsync_n)
			begin
				check_count("hsync_n period", count_t'(cycles), count_t'(800));
				if (high != 0)
				begin
					check_count("blank_n width", count_t'(high), count_t'(640));
					active++;
				end
				lines++;
				cycles = 0;
				high = 0;
			end
			prev_h = hsync_n;
		end
		check_count("active lines seen", count_t'(active), count_t'(5));
	endtask

	// ends on a vsync_n falling edge, the next test starts there
	task automatic test_frame_timing;
		logic found;
		logic prev_h;
		logic prev_v;
		logic prev_b;
		int lines;
		int vlow;
		int active;
		wait_vsync_fall(found);
		prev_h = hsync_n;
		prev_v = vsync_n;
		prev_b = blank_n;
		lines = 0;
		vlow = 0;
		active = 0;
		while (found)
		begin
			@(negedge D_CLK);
			if (prev_h && !hsync_n)
			begin
				lines++;
				if (!prev_v)
					vlow++;
			end
			if (!prev_b && blank_n)
				active++;
			if (prev_v && !vsync_n)
				found = 1'b0;
			prev_h = hsync_n;
			prev_v = vsync_n;
			prev_b = blank_n;
		end
		check_count("lines per frame", count_t'(lines), count_t'(525));
		check_count("vsync_n low lines", count_t'(vlow), count_t'(2));
		check_count("active lines", count_t'(active), count_t'(480));
	endtask

	// checks one frame from the current frame start up to the next
	task automatic scan_frame(input logic white);
		logic prev_v;
		logic prev_b;
		logic done;
		int pix;
		int line;
		pixel_t exp;
		prev_v = vsync_n;
		prev_b = blank_n;
		done = 1'b0;
		pix = 0;
		line = 0;
		while (!done)
		begin
			@(negedge D_CLK);
			if (blank_n)
			begin
				exp = white ? COLOR_WHITE : expected_color((pix / 80) % 8, (line / 60) % 8);
				check_pixel("color", pixel_t'({red, grn, blu}), exp);
				pix++;
			end
			else
			begin
				check_pixel("blanked color", pixel_t'({red, grn, blu}), COLOR_BLACK);
				if (prev_b)
					line++;
				pix = 0;
			end
			if (prev_v && !vsync_n)
				done = 1'b1;
			prev_v = vsync_n;
			prev_b = blank_n;
		end
		check_count("lines scanned", count_t'(line), count_t'(480));
	endtask

	task automatic test_colour_bars;
		scan_frame(1'b0);
	endtask

	task automatic test_white_mode;
		flat_white = 1'b1;	// set at frame start, inside vertical blank
		scan_frame(1'b1);
		flat_white = 1'b0;
		scan_frame(1'b0);
	endtask

	// ----------------------------------------------------------
	// main sequence

	initial
	begin
		D_CLK = 1'b0;
		D_RST_N = 1'b0;
		flat_white = 1'b0;
		value_errs = 0;
		other_errs = 0;

		test_reset_levels();
		test_line_timing();
		test_frame_timing();
		test_colour_bars();
		test_white_mode();

		$display("value errors: %0d, other errors: %0d", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

//--- sources.f
colorbar_pkg.sv
vga_timing_gen.sv
bar_locator.sv
bar_palette.sv
pixel_output.sv
colorbar_vga.sv
colorbar_properties.sv
tb_colorbar_vga.sv

//--- Makefile
# Verilator build for the colour bar generator testbench

TOP = tb_colorbar_vga

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sources.f -o sim

run: build
	./obj_dir/sim | tee sim.log
	grep -q "\*\*\* PASSED \*\*\*" sim.log

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f sources.f

clean:
	rm -rf obj_dir sim.log
